//--- bench/procTb.sv
//##########################################################
// Processor testbench
// Directed programs checked against the write-back beats
//##########################################################
`timescale 1ns/1ns
`include "proc_params.svh"

module procTb;
    import procPkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int RUN_CYCLES   = 80;   // Program, drain and quiet window
    localparam int QUIET_CYCLES = 8;
    localparam int NUM_TESTS    = 6;
    localparam int CYCLE_LIMIT  = NUM_TESTS * (`IMEM_DEPTH + 2 * RESET_CYCLES + RUN_CYCLES);

    localparam word_t HALT_WORD = {`OPC_HALT, 11'd0};
    localparam word_t NOP_WORD  = {`OPC_NOP, 11'd0};

    logic        clk;
    logic        reset;
    logic        imemWrite;
    word_t       imemAddr;
    word_t       imemData;
    logic        wbEn;
    regAddr_t    wbAddr;
    word_t       wbData;
    logic        halted;
    logic        err;

    word_t       prog[$];
    regAddr_t    expAddr[$];
    word_t       expData[$];
    regAddr_t    gotAddr[$];
    word_t       gotData[$];
    logic [31:0] rngState = 32'h24da_452c;
    int          cycles = 0;

    proc dut_i (
        .clk(clk), .reset(reset), .imemWrite(imemWrite), .imemAddr(imemAddr),
        .imemData(imemData), .wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData),
        .halted(halted), .err(err)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            failRun($sformatf("Timeout after %0d cycles, the tests did not finish", cycles));
        end
    end

    task automatic failRun(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "%s", what);
    endtask

    task automatic checkWord(input string name, input word_t expVal, input word_t actVal);
        if (actVal !== expVal) begin
            failRun($sformatf("** Error: %s expected %h actual %h", name, expVal, actVal));
        end
    endtask

    task automatic checkAddr(input string name, input regAddr_t expVal, input regAddr_t actVal);
        if (actVal !== expVal) begin
            failRun($sformatf("** Error: %s expected R%0d actual R%0d", name, expVal, actVal));
        end
    endtask

    task automatic checkFlag(input string name, input logic expVal, input logic actVal);
        if (actVal !== expVal) begin
            failRun($sformatf("** Error: %s expected %b actual %b", name, expVal, actVal));
        end
    endtask

    function automatic logic [31:0] nextRandom();
        logic [31:0] x;
        x = rngState;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rngState = x;
        return x;
    endfunction

    function automatic word_t sext5(input logic [4:0] v);
        return {{11{v[4]}}, v};
    endfunction

    function automatic word_t sext8(input logic [7:0] v);
        return {{8{v[7]}}, v};
    endfunction

    // ADDI, XORI, ST and LD
    function automatic word_t encImm(input logic [4:0] opc, input regAddr_t rs,
                                     input regAddr_t rd, input logic [4:0] imm);
        return {opc, rs, rd, imm};
    endfunction

    function automatic word_t encReg(input regAddr_t rs, input regAddr_t rt,
                                     input regAddr_t rd, input logic [1:0] funct);
        return {`OPC_RTYPE, rs, rt, rd, funct};
    endfunction

    function automatic word_t encLbi(input regAddr_t rs, input logic [7:0] imm);
        return {`OPC_LBI, rs, imm};
    endfunction

    // From and to are word indices in the program
    function automatic word_t encBranch(input logic [4:0] opc, input regAddr_t rs,
                                        input int from, input int to);
        int d;
        d = 2 * (to - from) - 2;            // Byte offset from PC+2
        return {opc, rs, d[7:0]};
    endfunction

    function automatic word_t encJal(input int from, input int to);
        int d;
        d = 2 * (to - from) - 2;
        return {`OPC_JAL, d[10:0]};
    endfunction

    task automatic startProgram();
        prog.delete();
        expAddr.delete();
        expData.delete();
    endtask

    task automatic emit(input word_t w);
        prog.push_back(w);
    endtask

    task automatic pad(input int n);
        repeat (n) prog.push_back(NOP_WORD);
    endtask

    task automatic addBeat(input regAddr_t a, input word_t d);
        expAddr.push_back(a);
        expData.push_back(d);
    endtask

    task automatic runProgram(input string name, input logic expErr);
        @(negedge clk);
        reset = 1'b1;
        for (int i = 0; i < `IMEM_DEPTH; i++) begin
            imemWrite = 1'b1;
            imemAddr  = word_t'(2 * i);     // Byte address
            imemData  = (i < prog.size()) ? prog[i] : HALT_WORD;
            @(negedge clk);
        end
        imemWrite = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        checkFlag({name, " err in reset"}, 1'b0, err);
        checkFlag({name, " halted in reset"}, 1'b0, halted);
        gotAddr.delete();
        gotData.delete();
        reset = 1'b0;
        while (!halted) begin
            @(negedge clk);
            if (wbEn) begin
                gotAddr.push_back(wbAddr);
                gotData.push_back(wbData);
            end
            if (!expErr) begin
                checkFlag({name, " err"}, 1'b0, err);
            end
        end
        // Pipeline must stay quiet once halted
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            if (wbEn) begin
                failRun($sformatf("%s: register write to R%0d after halt", name, wbAddr));
            end
            checkFlag({name, " halted held"}, 1'b1, halted);
            checkFlag({name, " err after halt"}, expErr, err);
        end
        if (gotAddr.size() != expAddr.size()) begin
            failRun($sformatf("** Error: %s expected %0d write beats actual %0d",
                              name, expAddr.size(), gotAddr.size()));
        end
        foreach (expAddr[i]) begin
            checkAddr($sformatf("%s beat %0d address", name, i), expAddr[i], gotAddr[i]);
            checkWord($sformatf("%s beat %0d data", name, i), expData[i], gotData[i]);
        end
    endtask

    task automatic aluTest();
        logic [31:0] r;
        word_t       r1;
        word_t       r2;
        r  = nextRandom();
        r1 = sext8(r[7:0]);
        r2 = sext8(r[15:8]);
        startProgram();
        emit(encLbi(3'd1, r[7:0]));
        emit(encLbi(3'd2, r[15:8]));
        pad(2);                             // Producer to consumer distance
        emit(encImm(`OPC_ADDI, 3'd1, 3'd3, r[20:16]));
        emit(encImm(`OPC_XORI, 3'd2, 3'd4, r[25:21]));
        emit(encReg(3'd1, 3'd2, 3'd5, 2'd0));
        emit(encReg(3'd1, 3'd2, 3'd6, 2'd1));
        emit(encReg(3'd1, 3'd2, 3'd7, 2'd2));
        emit(encReg(3'd1, 3'd2, 3'd1, 2'd3));
        emit(HALT_WORD);
        addBeat(3'd1, r1);
        addBeat(3'd2, r2);
        addBeat(3'd3, r1 + sext5(r[20:16]));
        addBeat(3'd4, r2 ^ {11'd0, r[25:21]});
        addBeat(3'd5, r1 + r2);
        addBeat(3'd6, r2 - r1);             // Rt minus Rs
        addBeat(3'd7, r1 ^ r2);
        addBeat(3'd1, r1 & r2);
        runProgram("alu", 1'b0);
    endtask

    task automatic memoryTest();
        logic [31:0] r;
        logic [4:0]  offB;
        r    = nextRandom();
        offB = r[20:16] ^ 5'd1;             // Neighbouring word
        startProgram();
        emit(encLbi(3'd1, r[7:0]));
        emit(encLbi(3'd2, r[15:8]));
        pad(2);
        emit(encImm(`OPC_ST, 3'd1, 3'd2, r[20:16]));
        emit(encImm(`OPC_ST, 3'd1, 3'd1, offB));
        emit(encImm(`OPC_LD, 3'd1, 3'd4, offB));
        emit(encImm(`OPC_LD, 3'd1, 3'd3, r[20:16]));
        emit(HALT_WORD);
        addBeat(3'd1, sext8(r[7:0]));
        addBeat(3'd2, sext8(r[15:8]));
        addBeat(3'd4, sext8(r[7:0]));
        addBeat(3'd3, sext8(r[15:8]));
        runProgram("memory", 1'b0);
    endtask

    task automatic branchTest();
        startProgram();
        emit(encLbi(3'd1, 8'h00));                  // 0
        emit(encLbi(3'd2, 8'h05));                  // 1
        pad(2);
        emit(encBranch(`OPC_BEQZ, 3'd1, 4, 7));     // 4 taken
        emit(encLbi(3'd3, 8'h11));                  // Squashed
        emit(encLbi(3'd3, 8'h22));                  // Skipped
        emit(encBranch(`OPC_BNEZ, 3'd2, 7, 10));    // 7 taken
        emit(encLbi(3'd4, 8'h33));
        emit(encLbi(3'd4, 8'h44));
        emit(encBranch(`OPC_BEQZ, 3'd2, 10, 13));   // 10 falls through
        emit(encLbi(3'd5, 8'ha5));
        emit(encBranch(`OPC_BNEZ, 3'd1, 12, 14));   // 12 falls through
        emit(encLbi(3'd6, 8'h66));
        emit(HALT_WORD);
        addBeat(3'd1, 16'h0000);
        addBeat(3'd2, 16'h0005);
        addBeat(3'd5, sext8(8'ha5));
        addBeat(3'd6, 16'h0066);
        runProgram("branch", 1'b0);
    endtask

    task automatic jalTest();
        logic [31:0] r;
        r = nextRandom();
        startProgram();
        emit(encLbi(3'd1, r[7:0]));         // 0
        emit(encJal(1, 6));                 // 1
        emit(encLbi(3'd2, r[15:8]));        // Squashed
        emit(HALT_WORD);
        emit(encLbi(3'd5, r[31:24]));       // 4, reached backwards
        emit(HALT_WORD);
        emit(encLbi(3'd4, r[23:16]));       // 6
        emit(encJal(7, 4));
        emit(encLbi(3'd6, r[15:8]));        // Squashed
        emit(HALT_WORD);
        addBeat(3'd1, sext8(r[7:0]));
        addBeat(3'd7, word_t'(2 * 1 + 2));
        addBeat(3'd4, sext8(r[23:16]));
        addBeat(3'd7, word_t'(2 * 7 + 2));
        addBeat(3'd5, sext8(r[31:24]));
        runProgram("jal", 1'b0);
    endtask

    task automatic haltTest();
        logic [31:0] r;
        r = nextRandom();
        startProgram();
        emit(encLbi(3'd1, r[7:0]));
        emit(encLbi(3'd2, r[15:8]));
        emit(HALT_WORD);
        emit(encLbi(3'd3, r[23:16]));       // Must never write
        emit(encLbi(3'd4, r[31:24]));
        addBeat(3'd1, sext8(r[7:0]));
        addBeat(3'd2, sext8(r[15:8]));
        runProgram("halt", 1'b0);
    endtask

    task automatic illegalTest();
        logic [31:0] r;
        r = nextRandom();
        startProgram();
        emit(encLbi(3'd1, r[7:0]));
        emit({5'b11111, 3'd2, r[15:8]});    // Unassigned opcode
        emit(encLbi(3'd2, r[23:16]));
        emit(HALT_WORD);
        addBeat(3'd1, sext8(r[7:0]));
        addBeat(3'd2, sext8(r[23:16]));
        runProgram("illegal", 1'b1);
        @(negedge clk);
        reset = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        checkFlag("illegal err cleared by reset", 1'b0, err);
    endtask

    initial begin
        reset     = 1'b1;
        imemWrite = 1'b0;
        imemAddr  = '0;
        imemData  = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        aluTest();
        memoryTest();
        branchTest();
        jalTest();
        haltTest();
        illegalTest();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- common/procPkg.sv
//##########################################################
// Processor package
// Shared types and field encodings for the 16-bit pipeline
//##########################################################
`include "proc_params.svh"

package procPkg;

    typedef logic [`WORD_W-1:0] word_t;     // Data, instruction and address
    typedef logic [2:0]         regAddr_t;  // R0 to R7
    typedef logic [1:0]         destSel_t;  // Destination register field
    typedef logic [1:0]         aluOp_t;

    // Destination field choices
    localparam destSel_t DEST_RS  = 2'd0;   // Bits 10:8
    localparam destSel_t DEST_RDR = 2'd1;   // Bits 4:2
    localparam destSel_t DEST_R7  = 2'd2;
    localparam destSel_t DEST_RDI = 2'd3;   // Bits 7:5

    // Matches the R-type funct field
    localparam aluOp_t ALU_ADD = 2'd0;
    localparam aluOp_t ALU_SUB = 2'd1;      // Rt minus Rs
    localparam aluOp_t ALU_XOR = 2'd2;
    localparam aluOp_t ALU_AND = 2'd3;

    typedef enum logic [1:0] {
        RUN,
        DRAIN,
        HALTED
    } runState_t;

endpackage

//--- common/proc_params.svh
//##########################################################
// Processor parameters
// Widths, memory depths and opcode encodings
//##########################################################
`ifndef PROC_PARAMS_SVH
`define PROC_PARAMS_SVH

`define WORD_W       16
`define IMEM_DEPTH   256
`define DMEM_DEPTH   256
`define DRAIN_CYCLES 3   // HALT in decode to HALT in writeback

// Opcodes in bits 15:11
`define OPC_HALT  5'b00000
`define OPC_NOP   5'b00001
`define OPC_JAL   5'b00110
`define OPC_ADDI  5'b01000
`define OPC_XORI  5'b01010
`define OPC_BEQZ  5'b01100
`define OPC_BNEZ  5'b01101
`define OPC_ST    5'b10000
`define OPC_LD    5'b10001
`define OPC_LBI   5'b11000
`define OPC_RTYPE 5'b11011   // Funct in bits 1:0

`endif

//--- hw/control/procControl.sv
//##########################################################
// Instruction decoder and run control
// Control bits for the decode instruction, drain and halt
//##########################################################
`timescale 1ns/1ns
`include "proc_params.svh"

module procControl (
    input  logic              clk,
    input  logic              reset,
    input  procPkg::word_t    instr,
    input  logic              instrValid,
    output procPkg::destSel_t destSel,
    output logic              immSext,
    output logic              immWide,
    output logic              lbiSel,
    output logic              linkWrite,
    output logic              branchEq,
    output logic              branchNe,
    output logic              jump,
    output procPkg::aluOp_t   aluOp,
    output logic              aluSrcImm,
    output logic              memRead,
    output logic              memWrite,
    output logic              regWrite,
    output logic              stopFetch,
    output logic              halted,
    output logic              err
);
    import procPkg::*;

    localparam int CNT_W = $clog2(`DRAIN_CYCLES);

    logic [14:0]      ctrl;
    logic             isHalt;
    logic             illegal;
    runState_t        state;
    logic [CNT_W-1:0] drainCnt;

    assign {destSel, immSext, immWide, lbiSel, linkWrite, branchEq, branchNe, jump,
            aluOp, aluSrcImm, memRead, memWrite, regWrite} = ctrl;

    // Bit order is dest, sext wide lbi link beq bne jump, alu, src rd wr regwr
    always_comb begin
        ctrl    = '0;
        isHalt  = 1'b0;
        illegal = 1'b0;
        if (instrValid) begin
            case (instr[15:11])
                `OPC_ADDI:  ctrl = {DEST_RDI, 7'b1000000, ALU_ADD, 4'b1001};
                `OPC_XORI:  ctrl = {DEST_RDI, 7'b0000000, ALU_XOR, 4'b1001};
                `OPC_RTYPE: ctrl = {DEST_RDR, 7'b0000000, aluOp_t'(instr[1:0]), 4'b0001};
                `OPC_LBI:   ctrl = {DEST_RS,  7'b0110000, ALU_ADD, 4'b0001};
                `OPC_ST:    ctrl = {DEST_RS,  7'b1000000, ALU_ADD, 4'b1010};
                `OPC_LD:    ctrl = {DEST_RDI, 7'b1000000, ALU_ADD, 4'b1101};
                `OPC_BEQZ:  ctrl = {DEST_RS,  7'b0100100, ALU_ADD, 4'b0000};
                `OPC_BNEZ:  ctrl = {DEST_RS,  7'b0100010, ALU_ADD, 4'b0000};
                `OPC_JAL:   ctrl = {DEST_R7,  7'b0001001, ALU_ADD, 4'b0001};
                `OPC_NOP:   ctrl = '0;
                `OPC_HALT:  isHalt = 1'b1;
                default:    illegal = 1'b1;     // Controls stay zero
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= RUN;
            drainCnt <= '0;
        end else begin
            case (state)
                RUN: begin
                    if (isHalt) begin
                        state    <= DRAIN;
                        drainCnt <= CNT_W'(`DRAIN_CYCLES - 1);
                    end
                end
                DRAIN: begin
                    if (drainCnt == CNT_W'(1)) begin
                        state <= HALTED;        // HALT now in writeback
                    end
                    drainCnt <= drainCnt - CNT_W'(1);
                end
                default: state <= HALTED;   // Held until reset
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            err <= 1'b0;
        end else if (illegal) begin
            err <= 1'b1;                    // Sticky
        end
    end

    assign stopFetch = isHalt || (state != RUN);
    assign halted    = (state == HALTED);

    // Only bubbles reach decode once HALT has left it
    assert property (@(posedge clk) disable iff (reset) (state != RUN) |-> !instrValid);

endmodule

//--- hw/decode/decode.sv
//##########################################################
// Decode stage
// Operands, immediates, branch resolution, decode/execute reg
//##########################################################
`timescale 1ns/1ns

module decode (
    input  logic              clk,
    input  logic              reset,
    input  procPkg::word_t    instr,
    input  procPkg::word_t    pcNext,
    input  logic              instrValid,
    input  procPkg::destSel_t destSel,
    input  logic              immSext,
    input  logic              immWide,
    input  logic              linkWrite,
    input  logic              branchEq,
    input  logic              branchNe,
    input  logic              jump,
    input  procPkg::aluOp_t   aluOp,
    input  logic              aluSrcImm,
    input  logic              memRead,
    input  logic              memWrite,
    input  logic              regWrite,
    input  logic              lbiSel,
    input  logic              wbEn,
    input  procPkg::regAddr_t wbAddr,
    input  procPkg::word_t    wbData,
    output logic              redirect,
    output procPkg::word_t    target,
    output procPkg::word_t    exA,
    output procPkg::word_t    exB,
    output procPkg::word_t    exImm,
    output procPkg::word_t    exLink,
    output procPkg::regAddr_t exWriteAddr,
    output procPkg::aluOp_t   exAluOp,
    output logic              exAluSrcImm,
    output logic              exLbiSel,
    output logic              exLinkWrite,
    output logic              exMemRead,
    output logic              exMemWrite,
    output logic              exRegWrite
);
    import procPkg::*;

    word_t    rsVal;
    word_t    rtVal;
    word_t    imm;
    regAddr_t writeAddr;
    logic     rsZero;

    regFile regFile_i (
        .clk(clk), .reset(reset), .rdAddrA(instr[10:8]), .rdAddrB(instr[7:5]),
        .wrEn(wbEn), .wrAddr(wbAddr), .wrData(wbData), .rdDataA(rsVal), .rdDataB(rtVal)
    );

    always_comb begin
        if (jump) begin
            imm = word_t'(signed'(instr[10:0]));    // JAL displacement
        end else if (immWide) begin
            imm = word_t'(signed'(instr[7:0]));     // LBI and branches
        end else if (immSext) begin
            imm = word_t'(signed'(instr[4:0]));
        end else begin
            imm = word_t'(instr[4:0]);
        end
    end

    always_comb begin
        case (destSel)
            DEST_RS:  writeAddr = instr[10:8];
            DEST_RDR: writeAddr = instr[4:2];
            DEST_R7:  writeAddr = 3'd7;
            default:  writeAddr = instr[7:5];
        endcase
    end

    assign rsZero   = (rsVal == '0);
    assign redirect = instrValid && (jump || (branchEq && rsZero) || (branchNe && !rsZero));
    assign target   = pcNext + imm;

    // Decode/execute register
    always_ff @(posedge clk) begin
        if (reset) begin
            exMemRead  <= 1'b0;
            exMemWrite <= 1'b0;
            exRegWrite <= 1'b0;
        end else begin
            exMemRead  <= memRead;
            exMemWrite <= memWrite;
            exRegWrite <= regWrite;
        end
    end

    always_ff @(posedge clk) begin
        exA         <= rsVal;
        exB         <= rtVal;               // Also store data for ST
        exImm       <= imm;
        exLink      <= pcNext;              // Return address for JAL
        exWriteAddr <= writeAddr;
        exAluOp     <= aluOp;
        exAluSrcImm <= aluSrcImm;
        exLbiSel    <= lbiSel;
        exLinkWrite <= linkWrite;
    end

endmodule

//--- hw/decode/regFile.sv
//##########################################################
// Register file
// Eight registers, two reads, one write with write-through
//##########################################################
`timescale 1ns/1ns

module regFile (
    input  logic              clk,
    input  logic              reset,
    input  procPkg::regAddr_t rdAddrA,
    input  procPkg::regAddr_t rdAddrB,
    input  logic              wrEn,
    input  procPkg::regAddr_t wrAddr,
    input  procPkg::word_t    wrData,
    output procPkg::word_t    rdDataA,
    output procPkg::word_t    rdDataB
);
    import procPkg::*;

    word_t regs [8];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

    // Bypass the write in flight so decode sees it this cycle
    assign rdDataA = (wrEn && wrAddr == rdAddrA) ? wrData : regs[rdAddrA];
    assign rdDataB = (wrEn && wrAddr == rdAddrB) ? wrData : regs[rdAddrB];

    // Write address comes from the memory/writeback register
    assert property (@(posedge clk) disable iff (reset) wrEn |-> !$isunknown(wrAddr));

endmodule

//--- hw/execute/execute.sv
//##########################################################
// Execute stage
// ALU, result select and the execute/memory register
//##########################################################
`timescale 1ns/1ns

module execute (
    input  logic              clk,
    input  logic              reset,
    input  procPkg::word_t    exA,
    input  procPkg::word_t    exB,
    input  procPkg::word_t    exImm,
    input  procPkg::word_t    exLink,
    input  procPkg::regAddr_t exWriteAddr,
    input  procPkg::aluOp_t   aluOp,
    input  logic              aluSrcImm,
    input  logic              lbiSel,
    input  logic              linkWrite,
    input  logic              exMemRead,
    input  logic              exMemWrite,
    input  logic              regWrite,
    output procPkg::word_t    memAddr,
    output procPkg::word_t    memStore,
    output procPkg::word_t    memResult,
    output procPkg::regAddr_t memWriteAddr,
    output logic              memRead,
    output logic              memWrite,
    output logic              memRegWrite
);
    import procPkg::*;

    word_t aluB;
    word_t aluOut;
    word_t result;

    assign aluB = aluSrcImm ? exImm : exB;

    always_comb begin
        case (aluOp)
            ALU_SUB: aluOut = aluB - exA;   // Rt minus Rs
            ALU_XOR: aluOut = exA ^ aluB;
            ALU_AND: aluOut = exA & aluB;
            default: aluOut = exA + aluB;
        endcase
    end

    assign result = lbiSel ? exImm : (linkWrite ? exLink : aluOut);

    // Execute/memory register
    always_ff @(posedge clk) begin
        if (reset) begin
            memRead     <= 1'b0;
            memWrite    <= 1'b0;
            memRegWrite <= 1'b0;
        end else begin
            memRead     <= exMemRead;
            memWrite    <= exMemWrite;
            memRegWrite <= regWrite;
        end
    end

    always_ff @(posedge clk) begin
        memAddr      <= aluOut;             // Rs plus offset for LD and ST
        memStore     <= exB;
        memResult    <= result;
        memWriteAddr <= exWriteAddr;
    end

endmodule

//--- hw/fetch/fetch.sv
//##########################################################
// Fetch stage
// PC, loadable instruction memory, fetch/decode register
//##########################################################
`timescale 1ns/1ns
`include "proc_params.svh"

module fetch (
    input  logic           clk,
    input  logic           reset,
    input  logic           imemWrite,
    input  procPkg::word_t imemAddr,
    input  procPkg::word_t imemData,
    input  logic           stopFetch,
    input  logic           redirect,
    input  procPkg::word_t target,
    output procPkg::word_t instr,
    output procPkg::word_t pcNext,
    output logic           instrValid
);
    import procPkg::*;

    localparam int    IMEM_AW  = $clog2(`IMEM_DEPTH);
    localparam word_t NOP_WORD = word_t'({`OPC_NOP, 11'd0});

    word_t pc;
    word_t pcPlus2;
    word_t imem [`IMEM_DEPTH];

    assign pcPlus2 = pc + word_t'(2);

    // Byte addressed like the PC, loaded while in reset
    always_ff @(posedge clk) begin
        if (imemWrite) begin
            imem[imemAddr[IMEM_AW:1]] <= imemData;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (redirect) begin
            pc <= target;                   // Taken branch or JAL
        end else if (!stopFetch) begin
            pc <= pcPlus2;
        end
    end

    // Fetch/decode register
    always_ff @(posedge clk) begin
        if (reset || redirect || stopFetch) begin
            instr      <= NOP_WORD;         // Squashed slot
            instrValid <= 1'b0;
        end else begin
            instr      <= imem[pc[IMEM_AW:1]];
            instrValid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        pcNext <= pcPlus2;
    end

    // Redirect targets from decode must keep halfword alignment
    assert property (@(posedge clk) disable iff (reset) pc[0] == 1'b0);

endmodule

//--- hw/memory/memory.sv
//##########################################################
// Memory stage
// Data memory, writeback select, memory/writeback register
//##########################################################
`timescale 1ns/1ns
`include "proc_params.svh"

module memory (
    input  logic              clk,
    input  logic              reset,
    input  procPkg::word_t    memAddr,
    input  procPkg::word_t    memStore,
    input  procPkg::word_t    memResult,
    input  procPkg::regAddr_t memWriteAddr,
    input  logic              memRead,
    input  logic              memWrite,
    input  logic              memRegWrite,
    output logic              wbEn,
    output procPkg::regAddr_t wbAddr,
    output procPkg::word_t    wbData
);
    import procPkg::*;

    localparam int DMEM_AW = $clog2(`DMEM_DEPTH);

    word_t dmem [`DMEM_DEPTH];
    word_t loadData;

    always_ff @(posedge clk) begin
        if (memWrite) begin
            dmem[memAddr[DMEM_AW-1:0]] <= memStore;
        end
    end

    assign loadData = dmem[memAddr[DMEM_AW-1:0]];  // Word addressed

    // Memory/writeback register
    always_ff @(posedge clk) begin
        if (reset) begin
            wbEn <= 1'b0;
        end else begin
            wbEn <= memRegWrite;
        end
    end

    always_ff @(posedge clk) begin
        wbAddr <= memWriteAddr;
        wbData <= memRead ? loadData : memResult;
    end

endmodule

//--- hw/proc.sv
//##########################################################
// Processor top level
// Control and the four pipeline stage blocks
//##########################################################
`timescale 1ns/1ns

module proc (
    input  logic              clk,
    input  logic              reset,
    input  logic              imemWrite,
    input  procPkg::word_t    imemAddr,
    input  procPkg::word_t    imemData,
    output logic              wbEn,
    output procPkg::regAddr_t wbAddr,
    output procPkg::word_t    wbData,
    output logic              halted,
    output logic              err
);
    import procPkg::*;

    word_t    instr;
    word_t    pcNext;
    logic     instrValid;
    logic     stopFetch;
    logic     redirect;
    word_t    target;

    // Decode-stage controls
    destSel_t destSel;
    logic     immSext;
    logic     immWide;
    logic     branchEq;
    logic     branchNe;
    logic     jump;
    logic     idLinkWrite;
    aluOp_t   idAluOp;
    logic     idAluSrcImm;
    logic     idLbiSel;
    logic     idMemRead;
    logic     idMemWrite;
    logic     idRegWrite;

    // Decode/execute register
    word_t    exA;
    word_t    exB;
    word_t    exImm;
    word_t    exLink;
    regAddr_t exWriteAddr;
    aluOp_t   exAluOp;
    logic     exAluSrcImm;
    logic     exLbiSel;
    logic     exLinkWrite;
    logic     exMemRead;
    logic     exMemWrite;
    logic     exRegWrite;

    // Execute/memory register
    word_t    memAddr;
    word_t    memStore;
    word_t    memResult;
    regAddr_t memWriteAddr;
    logic     memRead;
    logic     memWrite;
    logic     memRegWrite;

    procControl control_i (
        .clk(clk), .reset(reset), .instr(instr), .instrValid(instrValid),
        .destSel(destSel), .immSext(immSext), .immWide(immWide), .lbiSel(idLbiSel),
        .linkWrite(idLinkWrite), .branchEq(branchEq), .branchNe(branchNe), .jump(jump),
        .aluOp(idAluOp), .aluSrcImm(idAluSrcImm), .memRead(idMemRead),
        .memWrite(idMemWrite), .regWrite(idRegWrite), .stopFetch(stopFetch),
        .halted(halted), .err(err)
    );

    fetch fetch_i (
        .clk(clk), .reset(reset), .imemWrite(imemWrite), .imemAddr(imemAddr),
        .imemData(imemData), .stopFetch(stopFetch), .redirect(redirect), .target(target),
        .instr(instr), .pcNext(pcNext), .instrValid(instrValid)
    );

    decode decode_i (
        .clk(clk), .reset(reset), .instr(instr), .pcNext(pcNext), .instrValid(instrValid),
        .destSel(destSel), .immSext(immSext), .immWide(immWide), .linkWrite(idLinkWrite),
        .branchEq(branchEq), .branchNe(branchNe), .jump(jump), .aluOp(idAluOp),
        .aluSrcImm(idAluSrcImm), .memRead(idMemRead), .memWrite(idMemWrite),
        .regWrite(idRegWrite), .lbiSel(idLbiSel), .wbEn(wbEn), .wbAddr(wbAddr),
        .wbData(wbData), .redirect(redirect), .target(target), .exA(exA), .exB(exB),
        .exImm(exImm), .exLink(exLink), .exWriteAddr(exWriteAddr), .exAluOp(exAluOp),
        .exAluSrcImm(exAluSrcImm), .exLbiSel(exLbiSel), .exLinkWrite(exLinkWrite),
        .exMemRead(exMemRead), .exMemWrite(exMemWrite), .exRegWrite(exRegWrite)
    );

    execute execute_i (
        .clk(clk), .reset(reset), .exA(exA), .exB(exB), .exImm(exImm), .exLink(exLink),
        .exWriteAddr(exWriteAddr), .aluOp(exAluOp), .aluSrcImm(exAluSrcImm),
        .lbiSel(exLbiSel), .linkWrite(exLinkWrite), .exMemRead(exMemRead),
        .exMemWrite(exMemWrite), .regWrite(exRegWrite), .memAddr(memAddr),
        .memStore(memStore), .memResult(memResult), .memWriteAddr(memWriteAddr),
        .memRead(memRead), .memWrite(memWrite), .memRegWrite(memRegWrite)
    );

    memory memory_i (
        .clk(clk), .reset(reset), .memAddr(memAddr), .memStore(memStore),
        .memResult(memResult), .memWriteAddr(memWriteAddr), .memRead(memRead),
        .memWrite(memWrite), .memRegWrite(memRegWrite), .wbEn(wbEn), .wbAddr(wbAddr),
        .wbData(wbData)
    );

endmodule

//--- proc.f
+incdir+common
common/procPkg.sv
hw/control/procControl.sv
hw/fetch/fetch.sv
hw/decode/regFile.sv
hw/decode/decode.sv
hw/execute/execute.sv
hw/memory/memory.sv
hw/proc.sv
bench/procTb.sv

//--- run.sh
#!/bin/sh
# Build the processor testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module procTb -f proc.f -o procSim &&
./obj_dir/procSim ||
exit 1
